// File: all.f
source/trace_pkg.sv
source/trace_issuer.sv
source/stage_slot.sv
source/retire_collector.sv
source/trace_axil_port.sv
source/pipe_trace_top.sv
verif/pipe_trace_assert.sv
verif/tb_pipe_trace.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message shows up
verilator --binary --timing --assert --top-module tb_pipe_trace -f all.f -o tb_sim \
    && ./obj_dir/tb_sim +verilator+error+limit+100 | tee /dev/stderr \
        | grep -q "ALL CHECKS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: source/pipe_trace_top.sv
// Top level of the pipeline trace unit
// Issuer, five stage slots, retire collector and AXI4-Lite port
`timescale 1ns/1ns

module pipe_trace_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             stall,
    input  logic [trace_pkg::WORD_W-1:0]     fetch_word,
    input  logic [trace_pkg::WORD_W-1:0]     decode_word,
    input  logic [trace_pkg::WORD_W-1:0]     execute_word,
    input  logic [trace_pkg::WORD_W-1:0]     memory_word,
    input  logic [trace_pkg::WORD_W-1:0]     wb_word,
    input  logic [trace_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [trace_pkg::AXI_DATA_W-1:0] wdata,
    input  logic [3:0]                       wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [trace_pkg::AXI_ADDR_W-1:0] araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [trace_pkg::AXI_DATA_W-1:0] rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  logic                             rready
);

    import trace_pkg::*;

    logic [NUM_STAGES-1:0][WORD_W-1:0] stage_words;   // Index 0 is fetch
    trace_rec_t        rec_chain [NUM_STAGES+1];      // Issuer, then each slot output
    logic [NUM_STAGES-1:0] slot_accept;               // Only slot 0 feeds back
    trace_rec_t        head_rec;
    logic [QCNT_W-1:0] q_count;
    logic [DROP_W-1:0] drop_count;
    logic [ID_W-1:0]   next_id;
    logic              run, pop, clear_drops;

    assign stage_words = {wb_word, memory_word, execute_word, decode_word, fetch_word};

    trace_issuer u_issuer (
        .clk(clk), .rst_n(rst_n), .run(run), .accept(slot_accept[0]),
        .new_rec(rec_chain[0]), .next_id(next_id)
    );

    //////////////////////////////////////////////////
    // Stage slots, fetch to write-back
    //////////////////////////////////////////////////
    for (genvar s = 0; s < NUM_STAGES; s++) begin : g_slot
        stage_slot #(.STAGE(s)) u_slot (
            .clk(clk), .rst_n(rst_n), .stall(stall),
            .in_rec(rec_chain[s]), .stage_word(stage_words[s]),
            .accept(slot_accept[s]), .out_rec(rec_chain[s+1])
        );
    end

    retire_collector u_collector (
        .clk(clk), .rst_n(rst_n), .ret_rec(rec_chain[NUM_STAGES]),
        .pop(pop), .clear_drops(clear_drops),
        .head_rec(head_rec), .q_count(q_count), .drop_count(drop_count)
    );

    trace_axil_port u_axil (
        .clk(clk), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .head_rec(head_rec), .q_count(q_count), .drop_count(drop_count),
        .next_id(next_id), .run(run), .pop(pop), .clear_drops(clear_drops)
    );

endmodule

// File: source/retire_collector.sv
// Retire collector
// Circular queue of retired trace records, 8 deep
// Saturating count of records lost on overflow
`timescale 1ns/1ns

module retire_collector (
    input  logic                         clk,
    input  logic                         rst_n,
    input  trace_pkg::trace_rec_t        ret_rec,      // Leaving the write-back slot
    input  logic                         pop,          // From the AXI port
    input  logic                         clear_drops,  // Write-one pulse from CTRL
    output trace_pkg::trace_rec_t        head_rec,     // Zero when empty
    output logic [trace_pkg::QCNT_W-1:0] q_count,
    output logic [trace_pkg::DROP_W-1:0] drop_count
);

    import trace_pkg::*;

    trace_rec_t        mem_q [QUEUE_DEPTH];   // Record storage
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [QCNT_W-1:0] count_q;
    logic [DROP_W-1:0] drops_q;
    logic              empty, full;
    logic              do_push, do_pop, do_drop;

    assign empty   = (count_q == '0);
    assign full    = (count_q == QCNT_W'(QUEUE_DEPTH));
    assign do_pop  = pop && !empty;                       // Ignore pop on empty
    assign do_push = ret_rec.valid && (!full || do_pop);  // Pop frees a place
    assign do_drop = ret_rec.valid && !do_push;           // Full, record lost

    // Storage write
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr] <= ret_rec;
        end
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;       // Both or neither
            endcase
        end
    end

    // Drop counter, clear wins over a drop in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drops_q <= '0;
        end else if (clear_drops) begin
            drops_q <= '0;
        end else if (do_drop && (drops_q != '1)) begin
            drops_q <= drops_q + 1'b1;
        end
    end

    assign head_rec   = empty ? '0 : mem_q[rd_ptr];
    assign q_count    = count_q;
    assign drop_count = drops_q;

endmodule

// File: source/stage_slot.sv
// One pipeline stage slot
// Holds, bubbles or advances the in-flight record under stall
// Merges this stage's status word into the presented record
`timescale 1ns/1ns

module stage_slot #(
    parameter int STAGE = 0          // 0 fetch .. 4 write-back
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         stall,       // CPU front-end stall
    input  trace_pkg::trace_rec_t        in_rec,      // From the previous slot or issuer
    input  logic [trace_pkg::WORD_W-1:0] stage_word,  // Status of the current occupant
    output logic                         accept,      // High when this slot loads
    output trace_pkg::trace_rec_t        out_rec
);

    import trace_pkg::*;

    // Role of this slot during a stall
    localparam bit HOLDS   = (STAGE < FRONT_STAGES);   // Front end keeps its record
    localparam bit BUBBLES = (STAGE == FRONT_STAGES);  // First stage after the front end

    trace_rec_t rec_q;           // Record held by this stage
    trace_rec_t merged;          // Held record plus live stage word
    logic       hold;

    assign hold   = stall && HOLDS;
    assign accept = !hold;

    // Word is refreshed every cycle, so the last one before leaving sticks
    always_comb begin
        merged              = rec_q;
        merged.words[STAGE] = stage_word;
    end

    assign out_rec = merged;

    //////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rec_q.valid <= 1'b0;   // Payload left as is
        end else if (hold) begin
            // Count stall cycles, saturating
            if (rec_q.valid && (rec_q.stall_cycles != '1)) begin
                rec_q.stall_cycles <= rec_q.stall_cycles + 1'b1;
            end
        end else if (stall && BUBBLES) begin
            rec_q <= '0;           // Invalid bubble behind the stalled front end
        end else begin
            rec_q <= in_rec;       // Normal advance
        end
    end

endmodule

// File: source/trace_axil_port.sv
// AXI4-Lite slave for the trace unit
// CTRL run bit and drop clear, STATUS, head-of-queue words
// Reading WORD4_POP pops the queue head at address acceptance
// One read and one write outstanding, fixed one-cycle latency
`timescale 1ns/1ns

module trace_axil_port (
    input  logic                             clk,
    input  logic                             rst_n,
    // Write channels
    input  logic [trace_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [trace_pkg::AXI_DATA_W-1:0] wdata,
    input  logic [3:0]                       wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,
    // Read channels
    input  logic [trace_pkg::AXI_ADDR_W-1:0] araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [trace_pkg::AXI_DATA_W-1:0] rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  logic                             rready,
    // Trace unit side
    input  trace_pkg::trace_rec_t            head_rec,
    input  logic [trace_pkg::QCNT_W-1:0]     q_count,
    input  logic [trace_pkg::DROP_W-1:0]     drop_count,
    input  logic [trace_pkg::ID_W-1:0]       next_id,
    output logic                             run,
    output logic                             pop,
    output logic                             clear_drops
);

    import trace_pkg::*;

    logic                  wr_fire;    // Address and data taken together
    logic                  ctrl_wr;    // Accepted write that hits CTRL
    logic                  rd_fire;
    logic [AXI_DATA_W-1:0] rd_data_c;  // Decoded read value
    logic [1:0]            rd_resp_c;

    //////////////////////////////////////////////////
    // Write path
    //////////////////////////////////////////////////
    assign wr_fire = awvalid && wvalid && !bvalid;   // Blocked while a response waits
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign ctrl_wr = wr_fire && (awaddr == REG_CTRL) && wstrb[0];

    assign clear_drops = ctrl_wr && wdata[1];        // Write-one pulse

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            run    <= 1'b0;
        end else begin
            if (wr_fire)     bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (ctrl_wr)     run    <= wdata[0];
        end
    end

    // Only CTRL is writable
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= (awaddr == REG_CTRL) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    //////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////
    assign rd_fire = arvalid && !rvalid;             // No new read while one is pending
    assign arready = rd_fire;
    assign pop     = rd_fire && (araddr == REG_WORD4_POP) && (q_count != '0);

    always_comb begin
        rd_data_c = '0;
        rd_resp_c = RESP_OKAY;
        case (araddr)
            REG_CTRL:      rd_data_c = {31'b0, run};   // Bit 1 reads zero
            REG_STATUS:    rd_data_c = {next_id, 8'h00, drop_count, 4'h0, q_count};
            REG_HEAD_INFO: rd_data_c = {16'h0000, head_rec.stall_cycles, head_rec.id};
            REG_WORDS01:   rd_data_c = {head_rec.words[1], head_rec.words[0]};
            REG_WORDS23:   rd_data_c = {head_rec.words[3], head_rec.words[2]};
            REG_WORD4_POP: rd_data_c = {16'h0000, head_rec.words[4]};
            default:       rd_resp_c = RESP_SLVERR;    // Unmapped
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Latched at acceptance, so a pop returns the old head
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_data_c;
            rresp <= rd_resp_c;
        end
    end

endmodule

// File: source/trace_issuer.sv
// Sequence id issuer
// Offers a fresh trace record to slot 0 while tracing runs
`timescale 1ns/1ns

module trace_issuer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,      // Tracing enabled
    input  logic                       accept,   // Slot 0 loads on this edge
    output trace_pkg::trace_rec_t      new_rec,
    output logic [trace_pkg::ID_W-1:0] next_id
);

    import trace_pkg::*;

    logic [ID_W-1:0] id_q;       // Id for the next instruction
    logic            take;       // Valid record consumed by slot 0

    // Fresh record, nothing collected yet
    always_comb begin
        new_rec       = '0;
        new_rec.valid = run;   // Only valid while running
        new_rec.id    = id_q;
    end

    assign take = accept && new_rec.valid;

    // Id counter
    // wraps at 2**ID_W
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_q <= '0;
        end else if (take) begin
            id_q <= id_q + 1'b1;
        end
    end

    assign next_id = id_q;       // Shown in STATUS

endmodule

// File: source/trace_pkg.sv
// Shared definitions for the pipeline trace unit
// Sizes of ids, stage words, counters and the record queue
// Trace record type carried from slot to slot
// AXI4-Lite register map and response codes
package trace_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////
    localparam int NUM_STAGES   = 5;                   // Fetch, decode, execute, memory, wb
    localparam int FRONT_STAGES = 2;                   // Stages that hold on a front-end stall
    localparam int ID_W         = 8;                   // Sequence id, wraps
    localparam int WORD_W       = 16;                  // Per-stage status word
    localparam int CNT_W        = 8;                   // Stall cycle counter, saturating
    localparam int QUEUE_DEPTH  = 8;
    localparam int PTR_W        = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W       = PTR_W + 1;           // Must reach QUEUE_DEPTH itself
    localparam int DROP_W       = 8;
    localparam int AXI_ADDR_W   = 8;
    localparam int AXI_DATA_W   = 32;

    // One instruction as it moves down the pipe
    typedef struct packed {
        logic                                valid;
        logic [ID_W-1:0]                     id;
        logic [NUM_STAGES-1:0][WORD_W-1:0]   words;        // Indexed by stage
        logic [CNT_W-1:0]                    stall_cycles;
    } trace_rec_t;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL      = 8'h00;  // Run, clear drops
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS    = 8'h04;  // Read only
    localparam logic [AXI_ADDR_W-1:0] REG_HEAD_INFO = 8'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_WORDS01   = 8'h0C;
    localparam logic [AXI_ADDR_W-1:0] REG_WORDS23   = 8'h10;
    localparam logic [AXI_ADDR_W-1:0] REG_WORD4_POP = 8'h14;  // Read pops the head

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: verif/pipe_trace_assert.sv
// Concurrent checks on the trace unit
// AXI responses held until taken, queue bound, no pop of an empty queue
`timescale 1ns/1ns

module pipe_trace_assert (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         bvalid,
    input logic                         bready,
    input logic                         rvalid,
    input logic                         rready,
    input logic [trace_pkg::QCNT_W-1:0] q_count,
    input trace_pkg::trace_rec_t        head_rec,
    input logic                         pop
);

    import trace_pkg::*;

    int fail_count;   // Read by the testbench at the end
    initial fail_count = 0;

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid && !bready) |=> bvalid)
        else begin $error("bvalid fell before bready"); fail_count++; end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> rvalid)
        else begin $error("rvalid fell before rready"); fail_count++; end

    a_q_bound: assert property (@(posedge clk) disable iff (!rst_n)
        q_count <= QCNT_W'(QUEUE_DEPTH))
        else begin $error("q_count above queue depth"); fail_count++; end

    // A pop must find a stored record at the head
    a_no_empty_pop: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> head_rec.valid)
        else begin $error("pop on empty queue"); fail_count++; end

endmodule

bind pipe_trace_top pipe_trace_assert u_assert (
    .clk(clk), .rst_n(rst_n), .bvalid(bvalid), .bready(bready),
    .rvalid(rvalid), .rready(rready), .q_count(q_count), .head_rec(head_rec),
    .pop(pop)
);

// File: verif/tb_pipe_trace.sv
// Testbench for the pipeline trace unit
// Clock, reset, AXI4-Lite read and write tasks
// Random stall and stage words, cycle model of the slots and the queue
// Six directed tests with a watchdog
`timescale 1ns/1ns

module tb_pipe_trace;

    import trace_pkg::*;

    localparam int DRAIN       = 20;                    // Idle cycles after run falls
    localparam int RUN2        = 6;
    localparam int RUN3        = 6;
    localparam int ROUNDS3     = 5;
    localparam int RUN4        = 20;
    localparam int HS_LIMIT    = 16;                    // Cycles allowed per handshake
    localparam int READ_BUDGET = QUEUE_DEPTH * 16 + 40;
    localparam int TOTAL_LEN   = 10 + 70 + (RUN2 + DRAIN + READ_BUDGET)
                               + ROUNDS3 * (RUN3 + DRAIN + READ_BUDGET)
                               + (RUN4 + DRAIN + READ_BUDGET + 40) + 40 + 40;

    logic                  clk, rst_n, stall;
    logic [WORD_W-1:0]     fetch_word, decode_word, execute_word, memory_word, wb_word;
    logic [AXI_ADDR_W-1:0] awaddr, araddr;
    logic [AXI_DATA_W-1:0] wdata, rdata;
    logic [3:0]            wstrb;
    logic                  awvalid, wvalid, bready, arvalid, rready;
    logic                  awready, wready, bvalid, arready, rvalid;
    logic [1:0]            bresp, rresp;

    // Reference model state
    trace_rec_t        m_slot [NUM_STAGES];   // Stored record per slot, live word not merged
    trace_rec_t        exp_q [$];             // Predicted queue, head first
    logic              m_run;
    logic [ID_W-1:0]   m_id;
    logic [DROP_W-1:0] m_drops;
    int                m_retired;             // Valid records leaving slot 4
    int                rand_pct;              // Stall probability in percent

    // Bus events seen in the last cycle
    logic                  w_seen, r_seen, b_seen, rd_seen;
    logic [1:0]            got_bresp, got_rresp, exp_rresp;
    logic [AXI_DATA_W-1:0] got_rdata, exp_rdata;
    int                    errors, passed, failed;

    pipe_trace_top UUT (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .fetch_word(fetch_word), .decode_word(decode_word), .execute_word(execute_word),
        .memory_word(memory_word), .wb_word(wb_word),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog
    initial begin
        #(2 * TOTAL_LEN * 4);
        $display("Error: watchdog expired after %0d cycles, tests did not finish", 2 * TOTAL_LEN);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [WORD_W-1:0] live_word(input int s);
        case (s)
            0:       return fetch_word;
            1:       return decode_word;
            2:       return execute_word;
            3:       return memory_word;
            default: return wb_word;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Model of one clock edge
    //////////////////////////////////////////////////
    task automatic model_edge(input logic pop_now, input logic clear_now);
        trace_rec_t pres [NUM_STAGES];   // What each slot presents downstream
        trace_rec_t ret;
        for (int s = 0; s < NUM_STAGES; s++) begin
            pres[s]          = m_slot[s];
            pres[s].words[s] = live_word(s);
        end
        ret = pres[NUM_STAGES-1];
        // Pop first, it frees a place for a record retiring now
        if (pop_now && exp_q.size() > 0) void'(exp_q.pop_front());
        if (ret.valid) begin
            m_retired++;
            if (exp_q.size() < QUEUE_DEPTH) exp_q.push_back(ret);
            else if (!clear_now && m_drops != 8'hFF) m_drops++;   // Lost, saturating
        end
        if (clear_now) m_drops = '0;
        m_slot[4] = pres[3];                 // Back end always advances
        m_slot[3] = pres[2];
        if (stall) begin
            m_slot[2] = '0;                  // Bubble behind the held front end
            for (int s = 0; s < 2; s++) begin
                if (m_slot[s].valid && m_slot[s].stall_cycles != 8'hFF) begin
                    m_slot[s].stall_cycles++;
                end
            end
        end else begin
            m_slot[2]       = pres[1];
            m_slot[1]       = pres[0];
            m_slot[0]       = '0;            // Fresh record from the issuer
            m_slot[0].valid = m_run;
            m_slot[0].id    = m_id;
            if (m_run) m_id++;
        end
    endtask

    // Register value predicted from the model
    task automatic reg_expect(input logic [AXI_ADDR_W-1:0] addr,
                              output logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
        trace_rec_t h;
        h    = (exp_q.size() > 0) ? exp_q[0] : '0;   // Head reads zero when empty
        data = '0;
        resp = RESP_OKAY;
        case (addr)
            REG_CTRL:      data[0] = m_run;
            REG_STATUS: begin
                data[3:0]   = 4'(exp_q.size());
                data[15:8]  = m_drops;
                data[31:24] = m_id;
            end
            REG_HEAD_INFO: data[15:0] = {h.stall_cycles, h.id};
            REG_WORDS01:   data = {h.words[1], h.words[0]};
            REG_WORDS23:   data = {h.words[3], h.words[2]};
            REG_WORD4_POP: data[15:0] = h.words[4];
            default:       resp = RESP_SLVERR;
        endcase
    endtask

    // Sample mid-cycle, step the model, then drive new inputs after the edge
    task automatic next_cycle();
        logic pop_now;
        logic clear_now;
        @(negedge clk);
        w_seen  = awvalid && wvalid && awready && wready;
        r_seen  = arvalid && arready;
        b_seen  = bvalid && bready;
        rd_seen = rvalid && rready;
        if (b_seen) got_bresp = bresp;
        if (rd_seen) begin
            got_rdata = rdata;
            got_rresp = rresp;
        end
        if (r_seen) reg_expect(araddr, exp_rdata, exp_rresp);   // State before the edge
        pop_now   = r_seen && (araddr == REG_WORD4_POP);
        clear_now = w_seen && (awaddr == REG_CTRL) && wstrb[0] && wdata[1];
        model_edge(pop_now, clear_now);
        if (w_seen && (awaddr == REG_CTRL) && wstrb[0]) m_run = wdata[0];
        @(posedge clk);
        #1;
        stall        = ($urandom_range(99, 0) < rand_pct);
        fetch_word   = WORD_W'($urandom);
        decode_word  = WORD_W'($urandom);
        execute_word = WORD_W'($urandom);
        memory_word  = WORD_W'($urandom);
        wb_word      = WORD_W'($urandom);
    endtask

    //////////////////////////////////////////////////
    // AXI4-Lite master
    //////////////////////////////////////////////////
    task automatic bus_write(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data);
        int         n;
        logic [1:0] want;
        want    = (addr == REG_CTRL) ? RESP_OKAY : RESP_SLVERR;   // Only CTRL is writable
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n       = 0;
        do begin
            next_cycle();
            n++;
        end while (!w_seen && n < HS_LIMIT);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!w_seen) begin
            $display("Error at %0t ns: write to %h was never accepted", $time, addr);
            errors++;
            return;
        end
        bready = 1'b0;                        // Response has to wait a cycle or two
        repeat ($urandom_range(2, 1)) next_cycle();
        bready = 1'b1;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (!b_seen && n < HS_LIMIT);
        if (!b_seen) begin
            $display("Error at %0t ns: no write response for address %h", $time, addr);
            errors++;
        end else if (got_bresp !== want) begin
            $display("Fail at %0t ns: bresp for %h is %b, expected %b", $time, addr, got_bresp, want);
            errors++;
        end
    endtask

    task automatic bus_read(input string name, input logic [AXI_ADDR_W-1:0] addr,
                            output logic [AXI_DATA_W-1:0] data);
        int                    n;
        logic [AXI_DATA_W-1:0] want;
        logic [1:0]            want_resp;
        data    = '0;
        araddr  = addr;
        arvalid = 1'b1;
        n       = 0;
        do begin
            next_cycle();
            n++;
        end while (!r_seen && n < HS_LIMIT);
        arvalid = 1'b0;
        if (!r_seen) begin
            $display("Error at %0t ns: read of %s was never accepted", $time, name);
            errors++;
            return;
        end
        want      = exp_rdata;
        want_resp = exp_rresp;
        rready    = 1'b0;                     // Read data must hold while not taken
        repeat ($urandom_range(2, 1)) next_cycle();
        rready    = 1'b1;
        n         = 0;
        do begin
            next_cycle();
            n++;
        end while (!rd_seen && n < HS_LIMIT);
        if (!rd_seen) begin
            $display("Error at %0t ns: no read data returned for %s", $time, name);
            errors++;
            return;
        end
        if (got_rdata !== want) begin
            $display("Fail at %0t ns: rdata of %s is %h, expected %h", $time, name, got_rdata, want);
            errors++;
        end
        if (got_rresp !== want_resp) begin
            $display("Fail at %0t ns: rresp of %s is %b, expected %b",
                     $time, name, got_rresp, want_resp);
            errors++;
        end
        data = got_rdata;
    endtask

    // Trace a burst, then let the pipe empty
    task automatic run_trace(input int cycles, input int pct);
        rand_pct = pct;
        bus_write(REG_CTRL, 32'h1);
        repeat (cycles) next_cycle();
        bus_write(REG_CTRL, 32'h0);
        repeat (DRAIN) next_cycle();
        rand_pct = 0;
    endtask

    // Read and pop every queued record, each register checked against the model
    task automatic drain_queue();
        logic [AXI_DATA_W-1:0] d;
        int                    n;
        n = 0;
        bus_read("STATUS", REG_STATUS, d);
        while (exp_q.size() > 0 && n < QUEUE_DEPTH + 4) begin
            bus_read("HEAD_INFO", REG_HEAD_INFO, d);
            bus_read("WORDS01", REG_WORDS01, d);
            bus_read("WORDS23", REG_WORDS23, d);
            bus_read("WORD4_POP", REG_WORD4_POP, d);
            n++;
        end
        bus_read("STATUS", REG_STATUS, d);
    endtask

    task automatic end_test(input int num, input string name, input int err_start);
        if (errors == err_start) begin
            $display("Test %0d %s: passed", num, name);
            passed++;
        end else begin
            $display("Test %0d %s: failed with %0d errors", num, name, errors - err_start);
            failed++;
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        logic [AXI_DATA_W-1:0] d;
        int                    e;
        void'($urandom(99266));
        rst_n   = 1'b0;
        stall   = 1'b0;
        {fetch_word, decode_word, execute_word, memory_word, wb_word} = '0;
        awaddr  = '0;
        araddr  = '0;
        wdata   = '0;
        wstrb   = 4'h0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
        bready  = 1'b1;       // Dropped only while a response is held off
        rready  = 1'b1;
        {w_seen, r_seen, b_seen, rd_seen} = '0;
        {got_bresp, got_rresp, exp_rresp} = '0;
        got_rdata = '0;
        exp_rdata = '0;
        for (int s = 0; s < NUM_STAGES; s++) m_slot[s] = '0;
        m_run     = 1'b0;
        m_id      = '0;
        m_drops   = '0;
        m_retired = 0;
        rand_pct  = 0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        e = errors;                                  // Reset state, idle pipe
        bus_read("CTRL", REG_CTRL, d);
        bus_read("STATUS", REG_STATUS, d);
        rand_pct = 25;
        repeat (30) next_cycle();
        rand_pct = 0;
        bus_read("STATUS", REG_STATUS, d);
        if (d[3:0] !== 4'd0) begin
            $display("Fail at %0t ns: q_count is %0d, expected 0", $time, d[3:0]);
            errors++;
        end
        end_test(1, "reset and idle", e);

        e = errors;                                  // No stalls
        run_trace(RUN2, 0);
        bus_read("HEAD_INFO", REG_HEAD_INFO, d);
        if (d[15:0] !== 16'h0000) begin
            $display("Fail at %0t ns: first head id and stalls are %h, expected 0000",
                     $time, d[15:0]);
            errors++;
        end
        drain_queue();
        end_test(2, "stall free ids", e);

        e = errors;                                  // Random stalls
        for (int k = 0; k < ROUNDS3; k++) begin
            run_trace(RUN3, 25);
            drain_queue();
        end
        end_test(3, "random stalls", e);

        e = errors;                                  // Overflow and drop clear
        bus_write(REG_CTRL, 32'h2);
        m_retired = 0;
        run_trace(RUN4, 25);
        bus_read("STATUS", REG_STATUS, d);
        if (d[3:0] !== 4'd8) begin
            $display("Fail at %0t ns: q_count is %0d, expected 8", $time, d[3:0]);
            errors++;
        end
        if (d[15:8] !== 8'(m_retired - QUEUE_DEPTH)) begin
            $display("Fail at %0t ns: drop_count is %0d, expected %0d",
                     $time, d[15:8], m_retired - QUEUE_DEPTH);
            errors++;
        end
        bus_write(REG_CTRL, 32'h2);
        bus_read("STATUS", REG_STATUS, d);
        if (d[15:8] !== 8'h00) begin
            $display("Fail at %0t ns: drop_count is %0d after clear, expected 0", $time, d[15:8]);
            errors++;
        end
        drain_queue();
        end_test(4, "overflow", e);

        e = errors;                                  // Error responses
        bus_read("unmapped 0x20", 8'h20, d);
        bus_write(REG_STATUS, 32'h1);
        bus_read("CTRL", REG_CTRL, d);
        bus_read("STATUS", REG_STATUS, d);
        end_test(5, "slave errors", e);

        e = errors;                                  // Pop on empty queue
        bus_read("WORD4_POP", REG_WORD4_POP, d);
        if (d !== '0) begin
            $display("Fail at %0t ns: WORD4_POP is %h on empty queue, expected 0", $time, d);
            errors++;
        end
        bus_read("HEAD_INFO", REG_HEAD_INFO, d);
        bus_read("STATUS", REG_STATUS, d);
        end_test(6, "empty pop", e);

        errors = errors + UUT.u_assert.fail_count;
        $display("Summary: %0d tests passed, %0d failed, %0d errors, %0d assertion failures",
                 passed, failed, errors, UUT.u_assert.fail_count);
        if (errors == 0 && failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
